//--- rtl/i2c_mon_defs.svh
`ifndef I2C_MON_DEFS_SVH
`define I2C_MON_DEFS_SVH

// receiver boards sit on consecutive addresses starting at the base
`define I2C_MERC_BASE      7'h10
// number of receiver boards on the backplane
`define I2C_MERC_COUNT     4

// exciter addresses, each carries one status word
`define I2C_ADDR_PENNY_FW  7'h15 // exciter firmware version
`define I2C_ADDR_ALC       7'h16 // alc reading, 12 bits
`define I2C_ADDR_FWD       7'h17 // forward power, 12 bits
`define I2C_ADDR_REV       7'h18 // reverse power, 12 bits

// equal consecutive samples needed before a filtered line may change
`define I2C_GLITCH_DEPTH   2

// the exciter range runs from the firmware address up to reverse power
// so these four must stay consecutive

`endif

//--- rtl/i2c_mon_pkg.sv
`default_nettype none

package i2c_mon_pkg;

	// receiver view, first byte carries the active low overload bit in bit 0
	typedef struct packed {
		logic [6:0] rsvd;    // upper bits of first byte, not used
		logic       ovld_n;  // bit 0 of first byte, low means overload
		logic [7:0] version; // second byte
	} merc_view_t;

	// power view, low nibble of first byte is the top of the reading
	typedef struct packed {
		logic [3:0]  unused;  // high nibble of first byte
		logic [11:0] reading; // {first[3:0], second}
	} power_view_t;

	// two data bytes of one write, first byte in the high half
	typedef union packed {
		merc_view_t  merc;
		power_view_t power;
	} status_payload_t;

	// where the tracker is inside a write transaction
	typedef enum logic [2:0] {
		ph_idle,     // waiting for a start
		ph_addr,     // seven address bits plus r/w
		ph_addr_ack, // slave acknowledge of the address
		ph_byte0,    // first data byte
		ph_ack0,     // acknowledge after first byte, value ignored
		ph_byte1     // second data byte
	} frame_phase_t;

endpackage

`default_nettype wire

//--- rtl/i2c_mon_if.sv
`timescale 1ns/1ps
`default_nettype none

// bus events from the line decoder, all single cycle except bit_value
interface line_event_if;
	logic start_seen; // sda fell while scl high
	logic stop_seen;  // sda rose while scl high
	logic bit_valid;  // filtered scl rising edge
	logic bit_value;  // filtered sda at that edge

	modport decoder (
		output start_seen,
		output stop_seen,
		output bit_valid,
		output bit_value
	);

	modport tracker (
		input start_seen,
		input stop_seen,
		input bit_valid,
		input bit_value
	);
endinterface

// received bytes of a matched write, handed to the status router
interface frame_if;
	import i2c_mon_pkg::*;

	logic [6:0]      addr;         // target address of current transaction
	status_payload_t payload;      // first byte high, second byte low
	logic            first_valid;  // first byte complete this cycle
	logic            second_valid; // second byte complete this cycle

	modport tracker (
		output addr,
		output payload,
		output first_valid,
		output second_valid
	);

	modport router (
		input addr,
		input payload,
		input first_valid,
		input second_valid
	);
endinterface

`default_nettype wire

//--- rtl/i2c_line_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_mon_defs.svh"

module i2c_line_decoder (
	input  logic          CLK,
	input  logic          rst_n,
	input  logic          scl,
	input  logic          sda,
	line_event_if.decoder ev
);

	localparam int depth = `I2C_GLITCH_DEPTH;
	localparam int cnt_w = $clog2(depth + 1);

	// both lines are handled side by side, index 1 is scl and 0 is sda
	localparam int ln_scl = 1;
	localparam int ln_sda = 0;

	logic [1:0]            sync1;  // first synchronizer stage
	logic [1:0]            sync2;  // second stage, safe to use
	logic [1:0]            filt;   // filtered line levels
	logic [1:0]            filt_d; // filtered levels one cycle back
	logic [1:0][cnt_w-1:0] cnt;    // run length of samples that differ from filt

	logic scl_hi;   // scl high now and in the previous cycle
	logic sda_fell;
	logic sda_rose;

	// a bus line idles high, so reset everything to one
	// to keep the first cycles after reset free of false edges
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			sync1  <= 2'b11;
			sync2  <= 2'b11;
			filt   <= 2'b11;
			filt_d <= 2'b11;
			cnt    <= '0;
		end else begin
			sync1  <= {scl, sda};
			sync2  <= sync1;
			filt_d <= filt; // previous level for edge detection
			for (int i = 0; i < 2; i++) begin
				if (sync2[i] == filt[i]) begin
					cnt[i] <= '0; // spike ended early, start over
				end else if (cnt[i] == cnt_w'(depth - 1)) begin
					filt[i] <= sync2[i]; // depth equal samples seen
					cnt[i]  <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	// a change at the pins shows up in filt after 2 + depth edges
	// events below are combinational from filt, so same latency

	assign scl_hi   = filt[ln_scl] & filt_d[ln_scl];
	assign sda_fell = filt_d[ln_sda] & ~filt[ln_sda];
	assign sda_rose = ~filt_d[ln_sda] & filt[ln_sda];

	assign ev.start_seen = scl_hi & sda_fell;
	assign ev.stop_seen  = scl_hi & sda_rose;
	assign ev.bit_valid  = filt[ln_scl] & ~filt_d[ln_scl]; // scl rising edge
	assign ev.bit_value  = filt[ln_sda];                   // sampled with the edge

	// a filtered level only moves to the value the synchronizer held
	// for the last two samples, so a one cycle spike never gets through
	a_filter_run: assert property (
		@(posedge CLK) disable iff (!rst_n)
		((filt ^ $past(filt)) & ((filt ^ $past(sync2)) | (filt ^ $past(sync2, 2)))) == 2'b00
	) else $error("filtered line changed without a steady run of samples");

endmodule

`default_nettype wire

//--- rtl/i2c_frame_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_mon_defs.svh"

module i2c_frame_tracker (
	input  logic          CLK,
	input  logic          rst_n,
	line_event_if.tracker ev,
	frame_if.tracker      fr
);

	import i2c_mon_pkg::*;

	frame_phase_t phase;
	logic [2:0]   bit_cnt;    // bit position inside address or data byte
	logic [6:0]   addr_q;     // shifted in address, msb first
	logic [15:0]  data_q;     // both data bytes as received
	logic [15:0]  data_d;     // data_q including the bit sampled this cycle
	logic         addr_hit;   // address is one we monitor
	logic         byte_done;  // eighth bit of a byte sampled now
	logic         first_seen; // first byte strobed since the last start

	assign addr_hit =
		(addr_q >= `I2C_MERC_BASE && addr_q < `I2C_MERC_BASE + `I2C_MERC_COUNT) ||
		(addr_q >= `I2C_ADDR_PENNY_FW && addr_q <= `I2C_ADDR_REV);

	assign byte_done = ev.bit_valid && (bit_cnt == 3'd7);

	// next payload value, the strobe cycle already sees the last bit
	always_comb begin
		data_d = data_q;
		if (ev.bit_valid && phase == ph_byte0)
			data_d[15:8] = {data_q[14:8], ev.bit_value}; // msb first
		if (ev.bit_valid && phase == ph_byte1)
			data_d[7:0] = {data_q[6:0], ev.bit_value};
	end

	always_ff @(posedge CLK) begin
		data_q <= data_d;
		// the eighth bit is r/w and is not kept
		if (phase == ph_addr && ev.bit_valid && bit_cnt != 3'd7)
			addr_q <= {addr_q[5:0], ev.bit_value};
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			phase   <= ph_idle;
			bit_cnt <= '0;
		end else if (ev.start_seen) begin
			phase   <= ph_addr; // also restarts a transaction in progress
			bit_cnt <= '0;
		end else if (ev.stop_seen) begin
			phase <= ph_idle;
		end else if (ev.bit_valid) begin
			case (phase)
				ph_addr: begin
					bit_cnt <= bit_cnt + 1'b1; // wraps to 0 after r/w bit
					if (bit_cnt == 3'd7)
						phase <= ph_addr_ack;
				end
				ph_addr_ack: begin
					// low sda means the board acknowledged
					phase <= (addr_hit && !ev.bit_value) ? ph_byte0 : ph_idle;
				end
				ph_byte0: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (byte_done)
						phase <= ph_ack0;
				end
				ph_ack0: phase <= ph_byte1; // ack level not checked
				ph_byte1: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (byte_done)
						phase <= ph_idle; // only two bytes per write
				end
				default: ; // idle ignores bits until a start
			endcase
		end
	end

	assign fr.addr         = addr_q;
	assign fr.payload      = data_d;
	assign fr.first_valid  = (phase == ph_byte0) && byte_done;
	assign fr.second_valid = (phase == ph_byte1) && byte_done;

	// remembers the first strobe so the second can be checked against it
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			first_seen <= 1'b0;
		else if (ev.start_seen)
			first_seen <= 1'b0;
		else if (fr.first_valid)
			first_seen <= 1'b1;
		else if (fr.second_valid)
			first_seen <= 1'b0;
	end

	// a strobe belongs to an address matched at its acknowledge,
	// and the address register must not have moved since
	a_strobe_matched: assert property (
		@(posedge CLK) disable iff (!rst_n)
		(fr.first_valid || fr.second_valid) |-> addr_hit
	) else $error("data strobe for an address that was never matched");

	a_second_after_first: assert property (
		@(posedge CLK) disable iff (!rst_n)
		fr.second_valid |-> first_seen
	) else $error("second byte without first byte in same transaction");

endmodule

`default_nettype wire

//--- rtl/status_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_mon_defs.svh"

module status_router (
	input  logic                           CLK,
	input  logic                           rst_n,
	frame_if.router                        fr,
	output logic [7:0]                     penny_fw,
	output logic [`I2C_MERC_COUNT-1:0][7:0] merc_version,
	output logic [`I2C_MERC_COUNT-1:0]     merc_ovld,
	output logic [11:0]                    alc,
	output logic [11:0]                    fwd,
	output logic [11:0]                    rev
);

	import i2c_mon_pkg::*;

	logic [`I2C_MERC_COUNT-1:0] merc_sel; // one hot over receiver boards
	logic                       penny_sel;
	logic [2:0]                 pwr_sel;  // alc, fwd, rev
	logic                       any_sel;
	logic [2:0][11:0]           pwr;      // power readings, same order as pwr_sel

	// address decode, receivers are consecutive from the base
	always_comb begin
		for (int i = 0; i < `I2C_MERC_COUNT; i++)
			merc_sel[i] = (fr.addr == 7'(`I2C_MERC_BASE + i));
	end

	assign penny_sel  = (fr.addr == `I2C_ADDR_PENNY_FW);
	assign pwr_sel[0] = (fr.addr == `I2C_ADDR_ALC);
	assign pwr_sel[1] = (fr.addr == `I2C_ADDR_FWD);
	assign pwr_sel[2] = (fr.addr == `I2C_ADDR_REV);
	assign any_sel    = (|merc_sel) | penny_sel | (|pwr_sel);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			penny_fw     <= '0;
			merc_version <= '0;
			merc_ovld    <= '0;
			pwr          <= '0;
		end else begin
			for (int i = 0; i < `I2C_MERC_COUNT; i++) begin
				if (merc_sel[i] && fr.first_valid)
					merc_ovld[i] <= ~fr.payload.merc.ovld_n; // board reports active low
				if (merc_sel[i] && fr.second_valid)
					merc_version[i] <= fr.payload.merc.version;
			end

			if (penny_sel && fr.second_valid)
				penny_fw <= fr.payload.merc.version; // version byte, same spot

			// high nibble on first byte, low byte on second
			// a stop after the first byte leaves the low byte as it was
			for (int p = 0; p < 3; p++) begin
				if (pwr_sel[p] && fr.first_valid)
					pwr[p][11:8] <= fr.payload.power.reading[11:8];
				if (pwr_sel[p] && fr.second_valid)
					pwr[p][7:0] <= fr.payload.power.reading[7:0];
			end
		end
	end

	assign alc = pwr[0];
	assign fwd = pwr[1];
	assign rev = pwr[2];

	// the tracker only strobes for addresses that this decode covers
	a_strobe_decoded: assert property (
		@(posedge CLK) disable iff (!rst_n)
		(fr.first_valid || fr.second_valid) |-> any_sel
	) else $error("strobe for undecoded address %h", fr.addr);

endmodule

`default_nettype wire

//--- rtl/i2c_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_mon_defs.svh"

module i2c_monitor_top (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic                           scl,          // bus clock, sampled only
	input  logic                           sda,          // bus data, sampled only
	output logic [7:0]                     penny_fw,     // exciter firmware version
	output logic [`I2C_MERC_COUNT-1:0][7:0] merc_version, // receiver firmware versions
	output logic [`I2C_MERC_COUNT-1:0]     merc_ovld,    // receiver adc overload flags
	output logic [11:0]                    alc,          // exciter output level
	output logic [11:0]                    fwd,          // forward power
	output logic [11:0]                    rev           // reverse power
);

	// bus events between decoder and tracker
	line_event_if ev_if ();

	// received bytes between tracker and router
	frame_if fr_if ();

	i2c_line_decoder u_decoder (
		.CLK   (CLK),
		.rst_n (rst_n),
		.scl   (scl),
		.sda   (sda),
		.ev    (ev_if.decoder)
	);

	i2c_frame_tracker u_tracker (
		.CLK   (CLK),
		.rst_n (rst_n),
		.ev    (ev_if.tracker),
		.fr    (fr_if.tracker)
	);

	// outputs change one cycle after the strobe of the last data bit
	status_router u_router (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.fr           (fr_if.router),
		.penny_fw     (penny_fw),
		.merc_version (merc_version),
		.merc_ovld    (merc_ovld),
		.alc          (alc),
		.fwd          (fwd),
		.rev          (rev)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic CLK,
	output logic rst_n
);

	localparam int half_period = 50; // 100 ns clock

	initial begin
		CLK = 1'b0;
		forever #half_period CLK = ~CLK;
	end

	// reset held low over the first three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge CLK);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_mon_defs.svh"

module tb_top;

	localparam int cols  = 6;   // addr ack nbytes byte0 byte1 expected
	localparam int rows  = 40;  // most rows the data file may hold
	localparam int limit = 200; // clocks allowed for outputs to settle

	logic CLK;
	logic rst_n;
	logic scl;
	logic sda;
	logic [7:0]                      penny_fw;
	logic [`I2C_MERC_COUNT-1:0][7:0] merc_version;
	logic [`I2C_MERC_COUNT-1:0]      merc_ovld;
	logic [11:0]                     alc;
	logic [11:0]                     fwd;
	logic [11:0]                     rev;
	logic [7:0]                      exp_penny; // model of the status registers
	logic [`I2C_MERC_COUNT-1:0][7:0] exp_ver;
	logic [`I2C_MERC_COUNT-1:0]      exp_ovld;
	logic [11:0]                     exp_alc;
	logic [11:0]                     exp_fwd;
	logic [11:0]                     exp_rev;
	logic [15:0]                     td [0:rows*cols-1]; // data file image

	tb_clock u_clock (.CLK(CLK), .rst_n(rst_n));

	i2c_monitor_top uut (.CLK(CLK), .rst_n(rst_n), .scl(scl), .sda(sda), .penny_fw(penny_fw),
		.merc_version(merc_version), .merc_ovld(merc_ovld), .alc(alc), .fwd(fwd), .rev(rev));

	task automatic tick(input int n);
		repeat (n) @(posedge CLK);
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_power(input string name, input logic [11:0] got, input logic [11:0] exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_all();
		check_byte("penny_fw", penny_fw, exp_penny);
		check_power("alc", alc, exp_alc);
		check_power("fwd", fwd, exp_fwd);
		check_power("rev", rev, exp_rev);
		for (int i = 0; i < `I2C_MERC_COUNT; i++) begin
			check_byte($sformatf("merc_version[%0d]", i), merc_version[i], exp_ver[i]);
			check_flag($sformatf("merc_ovld[%0d]", i), merc_ovld[i], exp_ovld[i]);
		end
	endtask

	// dut status word of an address, same layout as the data file column
	function automatic logic [15:0] status_word(input logic [6:0] a);
		int i;
		i = int'(a) - `I2C_MERC_BASE;
		if (i >= 0 && i < `I2C_MERC_COUNT)
			return {7'd0, merc_ovld[i], merc_version[i]};
		if (a == `I2C_ADDR_PENNY_FW)
			return {8'd0, penny_fw};
		if (a == `I2C_ADDR_ALC)
			return {4'd0, alc};
		if (a == `I2C_ADDR_FWD)
			return {4'd0, fwd};
		if (a == `I2C_ADDR_REV)
			return {4'd0, rev};
		return 16'd0;
	endfunction

	// poll on the falling edge where outputs are stable
	task automatic wait_settled(input logic [6:0] a, input int row);
		int n;
		n = 0;
		@(negedge CLK);
		while (status_word(a) !== target_value(a) && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (n >= limit)
			stop_run($sformatf("timeout: addressed status never reached the model after data row %0d",
				row));
		else
			check_all(); // boards not addressed must still hold their values
	endtask

	function automatic int spike_width();
		return 1 + ($urandom % (`I2C_GLITCH_DEPTH - 1)); // always shorter than the filter
	endfunction

	task automatic issue_start();
		sda <= 1'b0; // falls while scl high
		tick(10);
		scl <= 1'b0;
	endtask

	// one bit is 10 clocks with scl low and 10 with scl high
	task automatic shift_bit(input logic b);
		int  w;
		logic glitch;
		w      = spike_width();
		glitch = ($urandom % 4) == 0;
		tick(3);
		sda <= b;
		tick(3);
		if (glitch) begin
			scl <= 1'b1; // short false clock
			tick(w);
			scl <= 1'b0;
		end
		tick(glitch ? 4 - w : 4);
		scl <= 1'b1;
		tick(4);
		if (glitch) begin
			sda <= ~b; // would read as start or stop if it got through
			tick(w);
			sda <= b;
		end
		tick(glitch ? 6 - w : 6);
		scl <= 1'b0;
	endtask

	task automatic shift_byte(input logic [7:0] v);
		for (int i = 7; i >= 0; i--)
			shift_bit(v[i]); // msb first
	endtask

	task automatic issue_stop();
		tick(3);
		sda <= 1'b0;
		tick(7);
		scl <= 1'b1;
		tick(10);
		sda <= 1'b1; // rises while scl high
		tick(10);
	endtask

	// idle bus with one short spike on each line
	task automatic idle_spikes(input int n);
		int w;
		w = spike_width();
		tick(2);
		sda <= 1'b0;
		tick(w);
		sda <= 1'b1;
		tick(4);
		scl <= 1'b0;
		tick(w);
		scl <= 1'b1;
		tick(n);
	endtask

	// high nibble from the first byte, low byte from the second
	function automatic logic [11:0] power_after(input logic [11:0] old, input int n,
			input logic [7:0] b0, input logic [7:0] b1);
		power_after = old;
		if (n >= 1)
			power_after[11:8] = b0[3:0];
		if (n >= 2)
			power_after[7:0] = b1;
	endfunction

	task automatic update_model(input logic [6:0] a, input logic ack, input int n,
			input logic [7:0] b0, input logic [7:0] b1);
		int i;
		i = int'(a) - `I2C_MERC_BASE;
		if (ack == 1'b0 && i >= 0 && i < `I2C_MERC_COUNT) begin
			if (n >= 1)
				exp_ovld[i] = ~b0[0]; // board reports overload active low
			if (n >= 2)
				exp_ver[i] = b1;
		end else if (ack == 1'b0) begin
			if (a == `I2C_ADDR_PENNY_FW && n >= 2)
				exp_penny = b1;
			if (a == `I2C_ADDR_ALC)
				exp_alc = power_after(exp_alc, n, b0, b1);
			if (a == `I2C_ADDR_FWD)
				exp_fwd = power_after(exp_fwd, n, b0, b1);
			if (a == `I2C_ADDR_REV)
				exp_rev = power_after(exp_rev, n, b0, b1);
		end
	endtask

	// model word of the addressed status, compared with the data file column
	function automatic logic [15:0] target_value(input logic [6:0] a);
		int i;
		i = int'(a) - `I2C_MERC_BASE;
		if (i >= 0 && i < `I2C_MERC_COUNT)
			return {7'd0, exp_ovld[i], exp_ver[i]};
		if (a == `I2C_ADDR_PENNY_FW)
			return {8'd0, exp_penny};
		if (a == `I2C_ADDR_ALC)
			return {4'd0, exp_alc};
		if (a == `I2C_ADDR_FWD)
			return {4'd0, exp_fwd};
		if (a == `I2C_ADDR_REV)
			return {4'd0, exp_rev};
		return 16'd0;
	endfunction

	initial begin
		int         row;
		int         n;
		int         base;
		logic [6:0] addr;
		logic [7:0] b0;
		logic [7:0] b1;
		void'($urandom(78));
		scl       = 1'b1; // bus idles high
		sda       = 1'b1;
		exp_penny = '0;
		exp_ver   = '0;
		exp_ovld  = '0;
		exp_alc   = '0;
		exp_fwd   = '0;
		exp_rev   = '0;
		$readmemh("dv/i2c_testdata.txt", td);

		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(posedge CLK);
			n++;
		end
		if (rst_n !== 1'b1)
			stop_run("reset was never released");
		@(negedge CLK);
		check_all(); // everything zero out of reset

		row = 0;
		while (row < rows && td[row*cols] !== 16'hffff) begin
			base = row * cols;
			addr = td[base][6:0];
			b0   = td[base+3][7:0];
			b1   = td[base+4][7:0];
			idle_spikes(5 + int'($urandom % 20));
			issue_start();
			shift_byte({addr, 1'b0}); // write
			shift_bit(td[base+1][0]); // board acknowledge level
			for (int k = 0; k < int'(td[base+2]); k++) begin
				shift_byte(k == 0 ? b0 : b1);
				shift_bit(1'b0); // ack after data, ignored by the monitor
			end
			issue_stop();
			update_model(addr, td[base+1][0], int'(td[base+2]), b0, b1);
			if (target_value(addr) !== td[base+5])
				stop_run($sformatf("data row %0d expects 0x%h but the model holds 0x%h",
					row + 1, td[base+5], target_value(addr)));
			wait_settled(addr, row + 1);
			row++;
		end
		if (row == 0)
			stop_run("no transactions were read from the data file");
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/i2c_mon_pkg.sv
rtl/i2c_mon_if.sv
rtl/i2c_line_decoder.sv
rtl/i2c_frame_tracker.sv
rtl/status_router.sv
rtl/i2c_monitor_top.sv
dv/tb_clock.sv
dv/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build the I2C monitor testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sources.f

# the simulator exits non-zero on $fatal, the search below decides the result
out=$(./obj_dir/Vtb_top 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All tests passed"; then
	echo "simulation result: pass"
	exit 0
fi
echo "simulation result: fail"
exit 1

//--- dv/i2c_testdata.txt
// addr ack nbytes byte0 byte1 expected, ack 0 means the board acknowledges
// expected is the addressed status word after the row, {ovld, version} for receivers
10 0 2 fe a1 1a1
11 0 2 01 b2 0b2
12 0 2 00 c3 1c3
13 0 2 ff d4 0d4
15 0 2 77 42 042
16 0 2 a5 3c 53c
17 0 2 0f ff fff
18 0 2 f1 23 123
// outside both ranges or not acknowledged
14 0 2 00 99 000
19 0 2 00 99 000
0f 0 2 00 99 000
11 1 2 00 55 0b2
17 1 2 03 44 fff
// stop after the first byte
12 0 1 01 ee 0c3
16 0 1 0b 77 b3c
18 0 1 04 00 423
15 0 1 ff 00 042
// second round over the same boards
10 0 2 01 5a 05a
13 0 2 fe 66 166
17 0 2 12 34 234
18 0 2 3f 80 f80
16 0 2 00 00 000
15 0 2 00 9d 09d
50 0 2 12 34 000
11 0 2 aa 01 101
// end marker
ffff 0 0 00 00 000
